//--- Bender.yml
package:
  name: multicycle_controller

sources:
  # packages first, the controller depends on both
  - files:
      - common/isa_pkg.sv
      - common/ctrl_pkg.sv
      - logic/instr_class_decode.sv
      - sequencer/cycle_sequencer.sv
      - logic/strobe_gen.sv
      - logic/mux_select_gen.sv
      - logic/multicycle_controller.sv
  - target: simulation
    files:
      - sim/tb_multicycle_controller.sv

//--- common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        t1 = 3'd0,
        t2 = 3'd1,
        t3 = 3'd2,
        t4 = 3'd3,
        t5 = 3'd4,
        t6 = 3'd5,
        t7 = 3'd6,
        t8 = 3'd7
    } cycle_t;

    typedef enum logic [2:0] {
        alu_a_rs   = 3'd0,
        alu_a_pc   = 3'd1,
        alu_a_ext5 = 3'd2,
        alu_a_none = 3'd7
    } alu_a_sel_t;

    typedef enum logic [2:0] {
        alu_b_four  = 3'd0,
        alu_b_rt    = 3'd1,
        alu_b_ext16 = 3'd2,
        alu_b_ext18 = 3'd3,
        alu_b_none  = 3'd7
    } alu_b_sel_t;

    typedef enum logic [2:0] {
        pc_src_z    = 3'd0,
        pc_src_jal  = 3'd2,
        pc_src_j    = 3'd3,
        pc_src_rs   = 3'd4,
        pc_src_none = 3'd7
    } pc_src_t;

    typedef enum logic [2:0] {
        gr_wd_z    = 3'd0,
        gr_wd_drr  = 3'd1,
        gr_wd_hi   = 3'd2,
        gr_wd_lo   = 3'd3,
        gr_wd_pc   = 3'd4,
        gr_wd_none = 3'd7
    } gr_wdata_t;

    typedef enum logic [1:0] {
        gr_wa_rd   = 2'd0,
        gr_wa_rt   = 2'd1,
        gr_wa_r31  = 2'd2,
        gr_wa_none = 2'd3
    } gr_waddr_t;

    typedef enum logic [1:0] {
        hilo_rs   = 2'd0,
        hilo_mult = 2'd1,
        hilo_div  = 2'd2,
        hilo_none = 2'd3
    } hilo_src_t;

    // register and memory in/out strobes
    typedef struct packed {
        logic im_r;
        logic ir_in;
        logic pc_in;
        logic pc_out;
        logic z_in;
        logic z_out;
        logic gr_in;
        logic gr_r1_out;
        logic gr_r2_out;
        logic m_r;
        logic m_w;
        logic drw_in;
        logic drw_out;
        logic drr_in;
        logic drr_out;
        logic hi_in;
        logic hi_out;
        logic lo_in;
        logic lo_out;
    } reg_strobes_t;

    typedef struct packed {
        alu_a_sel_t       alu_a;
        alu_b_sel_t       alu_b;
        isa_pkg::alu_op_t alu_code;
        pc_src_t          pc_src;
        gr_wdata_t        gr_wdata;
        gr_waddr_t        gr_waddr;
        hilo_src_t        hi_src;
        hilo_src_t        lo_src;
        logic             ext16_unsigned;
    } mux_sel_t;

    typedef struct packed {
        logic mult_start;
        logic mult_signed;
        logic div_start;
        logic div_signed;
    } unit_start_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // decoded instruction type, numbered as the datapath decoder emits it
    typedef enum logic [5:0] {
        it_add     = 6'd0,
        it_addu    = 6'd1,
        it_sub     = 6'd2,
        it_subu    = 6'd3,
        it_and     = 6'd4,
        it_or      = 6'd5,
        it_xor     = 6'd6,
        it_nor     = 6'd7,
        it_slt     = 6'd8,
        it_sltu    = 6'd9,
        it_sll     = 6'd10,
        it_srl     = 6'd11,
        it_sra     = 6'd12,
        it_sllv    = 6'd13,
        it_srlv    = 6'd14,
        it_srav    = 6'd15,
        it_jr      = 6'd16,
        it_addi    = 6'd17,
        it_addiu   = 6'd18,
        it_andi    = 6'd19,
        it_ori     = 6'd20,
        it_xori    = 6'd21,
        it_lw      = 6'd22,
        it_sw      = 6'd23,
        it_beq     = 6'd24,
        it_bne     = 6'd25,
        it_slti    = 6'd26,
        it_sltiu   = 6'd27,
        it_lui     = 6'd28,
        it_j       = 6'd29,
        it_jal     = 6'd30,
        it_jalr    = 6'd31,
        it_mult    = 6'd32,
        it_multu   = 6'd33,
        it_div     = 6'd34,
        it_divu    = 6'd35,
        it_mflo    = 6'd36,
        it_mfhi    = 6'd37,
        it_mtlo    = 6'd38,
        it_mthi    = 6'd39,
        // 40..43 and 51..53 are not handled here
        it_lb      = 6'd44,
        it_lbu     = 6'd45,
        it_lh      = 6'd46,
        it_lhu     = 6'd47,
        it_sb      = 6'd48,
        it_sh      = 6'd49,
        it_bgez    = 6'd50,
        it_unknown = 6'd54
    } instr_type_t;

    // alu function codes
    typedef enum logic [3:0] {
        alu_addu = 4'b0000,
        alu_subu = 4'b0001,
        alu_add  = 4'b0010,
        alu_sub  = 4'b0011,
        alu_and  = 4'b0100,
        alu_or   = 4'b0101,
        alu_xor  = 4'b0110,
        alu_nor  = 4'b0111,
        alu_lui  = 4'b1000,
        alu_sltu = 4'b1010,
        alu_slt  = 4'b1011,
        alu_sra  = 4'b1100,
        alu_srl  = 4'b1101,
        alu_sll  = 4'b1110,
        alu_none = 4'b1111
    } alu_op_t;

    // one-hot class flags plus a few qualifiers
    typedef struct packed {
        logic r_alu;
        logic i_alu;
        logic shift;
        logic load;
        logic store;
        logic branch;
        logic j;
        logic jr;
        logic jal;
        logic jalr;
        logic muldiv;
        logic mfhi;
        logic mflo;
        logic mthi;
        logic mtlo;
        // branch condition select, only meaningful with branch
        logic br_ne;
        logic br_gez;
        logic is_mult;
        logic is_signed;
        logic zext_imm;
    } instr_class_t;

    typedef struct packed {
        logic is_byte;
        logic is_half;
        logic is_signed;
    } dmem_access_t;

endpackage

`default_nettype wire

//--- list.f
common/isa_pkg.sv
common/ctrl_pkg.sv
logic/instr_class_decode.sv
sequencer/cycle_sequencer.sv
logic/strobe_gen.sv
logic/mux_select_gen.sv
logic/multicycle_controller.sv
sim/tb_multicycle_controller.sv

//--- logic/instr_class_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_class_decode import isa_pkg::*; (
    input  instr_type_t  instr_type,
    output instr_class_t cls,
    output dmem_access_t dmem
);

    always_comb begin
        cls = '0;
        case (instr_type)
            it_add, it_addu, it_sub, it_subu, it_and, it_or, it_xor, it_nor,
            it_slt, it_sltu, it_sllv, it_srlv, it_srav: begin
                cls.r_alu = 1'b1;
            end
            it_sll, it_srl, it_sra: begin
                cls.shift = 1'b1;
            end
            it_addi, it_addiu, it_slti, it_sltiu, it_lui: begin
                cls.i_alu = 1'b1;
            end
            // logical immediates take a zero-extended operand
            it_andi, it_ori, it_xori: begin
                cls.i_alu    = 1'b1;
                cls.zext_imm = 1'b1;
            end
            it_lw, it_lb, it_lbu, it_lh, it_lhu: cls.load = 1'b1;
            it_sw, it_sb, it_sh: cls.store = 1'b1;
            it_beq: cls.branch = 1'b1;
            it_bne: begin
                cls.branch = 1'b1;
                cls.br_ne  = 1'b1;
            end
            it_bgez: begin
                cls.branch = 1'b1;
                cls.br_gez = 1'b1;
            end
            it_j:    cls.j = 1'b1;
            it_jr:   cls.jr = 1'b1;
            it_jal:  cls.jal = 1'b1;
            it_jalr: cls.jalr = 1'b1;
            it_mult, it_multu, it_div, it_divu: begin
                cls.muldiv    = 1'b1;
                cls.is_mult   = (instr_type == it_mult) || (instr_type == it_multu);
                cls.is_signed = (instr_type == it_mult) || (instr_type == it_div);
            end
            it_mfhi: cls.mfhi = 1'b1;
            it_mflo: cls.mflo = 1'b1;
            it_mthi: cls.mthi = 1'b1;
            it_mtlo: cls.mtlo = 1'b1;
            // unknown and unsupported codes leave every flag low
            default: cls = '0;
        endcase
    end

    // data memory access width and sign
    assign dmem.is_byte   = (instr_type == it_lb) || (instr_type == it_lbu)
                          || (instr_type == it_sb);
    assign dmem.is_half   = (instr_type == it_lh) || (instr_type == it_lhu)
                          || (instr_type == it_sh);
    assign dmem.is_signed = (instr_type == it_lb) || (instr_type == it_lh);

endmodule

`default_nettype wire

//--- logic/multicycle_controller.sv
`timescale 1ns/1ps
`default_nettype none

module multicycle_controller import isa_pkg::*, ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  instr_type_t  instr_type,
    input  alu_op_t      alu_op_in,
    input  logic         zero,
    input  logic         negative,
    input  logic         mult_busy,
    input  logic         div_busy,
    output reg_strobes_t strobes,
    output mux_sel_t     selects,
    output dmem_access_t dmem,
    output unit_start_t  start,
    output logic         instr_done
);

    instr_class_t cls;
    cycle_t       cycle;

    instr_class_decode u_decode (
        .instr_type (instr_type),
        .cls        (cls),
        .dmem       (dmem)
    );

    // only the sequencer sees alu flags and unit busy
    cycle_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cls        (cls),
        .zero       (zero),
        .negative   (negative),
        .mult_busy  (mult_busy),
        .div_busy   (div_busy),
        .cycle      (cycle),
        .start      (start),
        .instr_done (instr_done)
    );

    strobe_gen u_strobes (
        .cycle   (cycle),
        .cls     (cls),
        .strobes (strobes)
    );

    mux_select_gen u_selects (
        .cycle     (cycle),
        .cls       (cls),
        .alu_op_in (alu_op_in),
        .sel       (selects)
    );

endmodule

`default_nettype wire

//--- logic/mux_select_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mux_select_gen import isa_pkg::*, ctrl_pkg::*; (
    input  cycle_t       cycle,
    input  instr_class_t cls,
    input  alu_op_t      alu_op_in,
    output mux_sel_t     sel
);

    logic alu_cls;

    assign alu_cls = cls.r_alu | cls.i_alu | cls.shift;

    //////////////////////////////
    // alu operands and function
    always_comb begin
        sel.alu_a    = alu_a_none;
        sel.alu_b    = alu_b_none;
        sel.alu_code = alu_none;
        if (cycle == t1) begin
            // pc + 4
            sel.alu_a    = alu_a_pc;
            sel.alu_b    = alu_b_four;
            sel.alu_code = alu_addu;
        end else if (cls.branch) begin
            if (cycle == t3) begin
                // compare rs with rt
                sel.alu_a    = alu_a_rs;
                sel.alu_b    = alu_b_rt;
                sel.alu_code = alu_sub;
            end else if (cycle == t5) begin
                // branch target
                sel.alu_a    = alu_a_pc;
                sel.alu_b    = alu_b_ext18;
                sel.alu_code = alu_add;
            end
        end else if (cls.r_alu) begin
            sel.alu_a    = alu_a_rs;
            sel.alu_b    = alu_b_rt;
            sel.alu_code = alu_op_in;
        end else if (cls.shift) begin
            sel.alu_a    = alu_a_ext5;
            sel.alu_b    = alu_b_rt;
            sel.alu_code = alu_op_in;
        end else if (cls.i_alu) begin
            sel.alu_a    = alu_a_rs;
            sel.alu_b    = alu_b_ext16;
            sel.alu_code = alu_op_in;
        end else if (cls.load || cls.store) begin
            // effective address
            sel.alu_a    = alu_a_rs;
            sel.alu_b    = alu_b_ext16;
            sel.alu_code = alu_addu;
        end
    end

    //////////////////////////////
    // pc write source
    always_comb begin
        if ((cycle == t2) || (cls.branch && (cycle == t6))) begin
            sel.pc_src = pc_src_z;
        end else if (cls.j && (cycle == t3)) begin
            sel.pc_src = pc_src_j;
        end else if (cls.jal && (cycle == t4)) begin
            sel.pc_src = pc_src_jal;
        end else if ((cls.jr && (cycle == t3)) || (cls.jalr && (cycle == t4))) begin
            sel.pc_src = pc_src_rs;
        end else begin
            sel.pc_src = pc_src_none;
        end
    end

    // register file write port
    always_comb begin
        if (alu_cls) begin
            sel.gr_wdata = gr_wd_z;
        end else if (cls.load) begin
            sel.gr_wdata = gr_wd_drr;
        end else if (cls.jal || cls.jalr) begin
            sel.gr_wdata = gr_wd_pc;
        end else if (cls.mfhi) begin
            sel.gr_wdata = gr_wd_hi;
        end else if (cls.mflo) begin
            sel.gr_wdata = gr_wd_lo;
        end else begin
            sel.gr_wdata = gr_wd_none;
        end

        if (cls.r_alu || cls.shift || cls.jalr || cls.mfhi || cls.mflo) begin
            sel.gr_waddr = gr_wa_rd;
        end else if (cls.i_alu || cls.load) begin
            sel.gr_waddr = gr_wa_rt;
        end else if (cls.jal) begin
            sel.gr_waddr = gr_wa_r31;
        end else begin
            sel.gr_waddr = gr_wa_none;
        end
    end

    // hi/lo write source, moves come from rs
    always_comb begin
        sel.hi_src = hilo_none;
        sel.lo_src = hilo_none;
        if (cls.muldiv) begin
            sel.hi_src = cls.is_mult ? hilo_mult : hilo_div;
            sel.lo_src = cls.is_mult ? hilo_mult : hilo_div;
        end else begin
            if (cls.mthi) begin
                sel.hi_src = hilo_rs;
            end
            if (cls.mtlo) begin
                sel.lo_src = hilo_rs;
            end
        end
    end

    assign sel.ext16_unsigned = cls.zext_imm;

endmodule

`default_nettype wire

//--- logic/strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module strobe_gen import isa_pkg::*, ctrl_pkg::*; (
    input  cycle_t       cycle,
    input  instr_class_t cls,
    output reg_strobes_t strobes
);

    logic alu_cls;
    logic link;
    logic c1;
    logic c2;
    logic c3;
    logic c4;
    logic c5;
    logic c6;

    assign alu_cls = cls.r_alu | cls.i_alu | cls.shift;
    assign link    = cls.jal | cls.jalr;

    assign c1 = (cycle == t1);
    assign c2 = (cycle == t2);
    assign c3 = (cycle == t3);
    assign c4 = (cycle == t4);
    assign c5 = (cycle == t5);
    assign c6 = (cycle == t6);

    // fetch
    assign strobes.im_r  = c1;
    assign strobes.ir_in = c1;

    // pc update and pc as an operand
    assign strobes.pc_in  = c2 | (cls.branch & c6) | ((cls.j | cls.jr) & c3) | (link & c4);
    assign strobes.pc_out = c1 | (cls.branch & c5) | (link & c3)
                          | (cls.j & c3) | (cls.jal & c4);

    // alu result register
    assign strobes.z_in  = c1 | (c3 & (alu_cls | cls.load | cls.store | cls.branch))
                         | (cls.branch & c5);
    assign strobes.z_out = c2 | (c4 & (alu_cls | cls.branch | cls.load))
                         | (cls.store & c5) | (cls.branch & c6);

    // general registers
    assign strobes.gr_in     = (c4 & alu_cls) | (c5 & cls.load)
                             | (c3 & (link | cls.mfhi | cls.mflo));
    assign strobes.gr_r1_out = (c3 & (cls.r_alu | cls.i_alu | cls.branch | cls.load
                             | cls.store | cls.jr | cls.muldiv | cls.mthi | cls.mtlo))
                             | (c4 & cls.jalr);
    assign strobes.gr_r2_out = (c3 & (cls.r_alu | cls.shift | cls.branch | cls.muldiv))
                             | (c4 & cls.store);

    // data memory and its buffers
    assign strobes.m_r     = cls.load & c4;
    assign strobes.m_w     = cls.store & c5;
    assign strobes.drw_in  = cls.store & c4;
    assign strobes.drw_out = cls.store & c5;
    assign strobes.drr_in  = cls.load & c4;
    assign strobes.drr_out = cls.load & c5;

    // hi/lo
    assign strobes.hi_in  = (c4 & cls.muldiv) | (c3 & cls.mthi);
    assign strobes.hi_out = c3 & cls.mfhi;
    assign strobes.lo_in  = (c4 & cls.muldiv) | (c3 & cls.mtlo);
    assign strobes.lo_out = c3 & cls.mflo;

endmodule

`default_nettype wire

//--- sequencer/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer import isa_pkg::*, ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  instr_class_t cls,
    input  logic         zero,
    input  logic         negative,
    input  logic         mult_busy,
    input  logic         div_busy,
    output cycle_t       cycle,
    output unit_start_t  start,
    output logic         instr_done
);

    cycle_t next_cycle;
    logic   short_instr;
    logic   branch_taken;
    logic   unit_wait;
    logic   mult_req;
    logic   div_req;
    logic   mult_start_q;
    logic   div_start_q;

    // instructions that finish in t3
    assign short_instr = cls.j | cls.jr | cls.mfhi | cls.mflo | cls.mthi | cls.mtlo;

    // beq on zero, bne on not zero, bgez on non-negative
    assign branch_taken = cls.branch
                        & (cls.br_gez ? ~negative : (cls.br_ne ? ~zero : zero));

    // hold t3 until the unit has seen its start and dropped busy
    assign unit_wait = cls.is_mult ? (mult_busy | mult_start_q)
                                   : (div_busy | div_start_q);

    //////////////////////////////
    // next cycle
    always_comb begin
        case (cycle)
            t1: next_cycle = t2;
            t2: next_cycle = t3;
            t3: begin
                if (short_instr) begin
                    next_cycle = t1;
                end else if (cls.muldiv && unit_wait) begin
                    next_cycle = t3;
                end else begin
                    next_cycle = t4;
                end
            end
            t4: begin
                if (branch_taken || cls.load || cls.store) begin
                    next_cycle = t5;
                end else begin
                    next_cycle = t1;
                end
            end
            t5: next_cycle = cls.branch ? t6 : t1;
            // t6 ends a taken branch and t8 only follows reset
            default: next_cycle = t1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle <= t8;
        end else begin
            cycle <= next_cycle;
        end
    end

    // the idle t8 after reset is not the end of an instruction
    assign instr_done = (next_cycle == t1) && (cycle != t8);

    //////////////////////////////
    // multiplier and divider start
    assign mult_req = cls.muldiv & cls.is_mult & ~mult_busy & (cycle == t2);
    assign div_req  = cls.muldiv & ~cls.is_mult & ~div_busy & (cycle == t2);

    // one-cycle pulses since a request only rises in t2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mult_start_q <= 1'b0;
            div_start_q  <= 1'b0;
        end else begin
            mult_start_q <= mult_req;
            div_start_q  <= div_req;
        end
    end

    assign start.mult_start  = mult_start_q;
    assign start.mult_signed = mult_start_q & cls.is_signed;
    assign start.div_start   = div_start_q;
    assign start.div_signed  = div_start_q & cls.is_signed;

endmodule

`default_nettype wire

//--- sim/tb_multicycle_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_multicycle_controller import isa_pkg::*, ctrl_pkg::*; ();

    localparam int n_instr      = 500;
    localparam int max_busy     = 6;
    localparam int reset_cycles = 5;
    // a full T1..T8 walk plus the longest busy stretch per instruction
    localparam int cycle_limit  = n_instr * (8 + max_busy) + reset_cycles;

    logic         clk        = 1'b0;
    logic         rst        = 1'b1;
    instr_type_t  instr_type = it_unknown;
    alu_op_t      alu_op_in  = alu_addu;
    logic         zero       = 1'b0;
    logic         negative   = 1'b0;
    logic         mult_busy  = 1'b0;
    logic         div_busy   = 1'b0;
    reg_strobes_t strobes;
    mux_sel_t     selects;
    dmem_access_t dmem;
    unit_start_t  start;
    logic         instr_done;

    // position inside the current instruction, 1 is its T1
    int   pos       = 0;
    int   len       = 0;
    logic taken     = 1'b0;
    int   wait_k    = 0;
    int   mult_left = 0;
    int   div_left  = 0;
    int   cycles    = 0;
    int   issued    = 0;
    int   errors    = 0;
    bit   timed_out = 1'b0;

    multicycle_controller DUT (
        .clk        (clk),
        .rst        (rst),
        .instr_type (instr_type),
        .alu_op_in  (alu_op_in),
        .zero       (zero),
        .negative   (negative),
        .mult_busy  (mult_busy),
        .div_busy   (div_busy),
        .strobes    (strobes),
        .selects    (selects),
        .dmem       (dmem),
        .start      (start),
        .instr_done (instr_done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    //////////////////////////////
    // instruction classes
    function automatic bit is_load(instr_type_t t);
        return t inside {it_lw, it_lb, it_lbu, it_lh, it_lhu};
    endfunction

    function automatic bit is_store(instr_type_t t);
        return t inside {it_sw, it_sb, it_sh};
    endfunction

    function automatic bit is_branch(instr_type_t t);
        return t inside {it_beq, it_bne, it_bgez};
    endfunction

    function automatic bit is_muldiv(instr_type_t t);
        return t inside {it_mult, it_multu, it_div, it_divu};
    endfunction

    // 1 writes rd, 2 writes rt, 0 for anything that is not an alu instruction
    function automatic int alu_dest(instr_type_t t);
        return (t inside {[it_add:it_srav]}) ? 1
             : (t inside {[it_addi:it_xori], it_slti, it_sltiu, it_lui}) ? 2 : 0;
    endfunction

    function automatic logic branch_cond(instr_type_t t, logic z, logic n);
        return (t == it_beq) ? z : (t == it_bne) ? ~z : ~n;
    endfunction

    function automatic int expected_len(instr_type_t t, logic tk, int k);
        if (t inside {it_j, it_jr, it_mfhi, it_mflo, it_mthi, it_mtlo}) begin
            return 3;
        end else if (is_load(t) || is_store(t)) begin
            return 5;
        end else if (is_branch(t)) begin
            return tk ? 6 : 4;
        end else if (is_muldiv(t)) begin
            // T3 holds through the start cycle and every busy cycle
            return 5 + k;
        end
        return 4;
    endfunction

    function automatic dmem_access_t expected_dmem(instr_type_t t);
        dmem_access_t d;
        d.is_byte   = t inside {it_lb, it_lbu, it_sb};
        d.is_half   = t inside {it_lh, it_lhu, it_sh};
        d.is_signed = t inside {it_lb, it_lh};
        return d;
    endfunction

    function automatic alu_op_t pick_alu_op();
        logic [3:0] v;
        v = 4'($urandom);
        // 4'b1001 is not an alu function
        if (v == 4'b1001) begin
            v = 4'b1111;
        end
        return alu_op_t'(v);
    endfunction

    task automatic report_mismatch(input string check, input int expected, input int actual);
        errors++;
        $display("error %s: expected 0x%0h actual 0x%0h", check, expected, actual);
    endtask

    // codes 40..43 and 51..53 decode as unknown
    task automatic launch_instr();
        logic [5:0]  code;
        instr_type_t ty;
        logic        z;
        logic        n;
        logic        tk;
        int          k;
        code = 6'($urandom % 55);
        ty   = instr_type_t'(code);
        z    = 1'($urandom);
        n    = 1'($urandom);
        k    = $urandom % (max_busy + 1);
        tk   = is_branch(ty) && branch_cond(ty, z, n);
        instr_type <= ty;
        alu_op_in  <= pick_alu_op();
        zero       <= z;
        negative   <= n;
        wait_k     <= k;
        taken      <= tk;
        len        <= expected_len(ty, tk, k);
        pos        <= 1;
        issued = issued + 1;
    endtask

    //////////////////////////////
    // multiplier and divider busy
    always @(posedge clk) begin
        if (start.mult_start) begin
            mult_left <= wait_k;
            mult_busy <= (wait_k != 0);
        end else if (mult_left > 1) begin
            mult_left <= mult_left - 1;
        end else begin
            mult_left <= 0;
            mult_busy <= 1'b0;
        end
        if (start.div_start) begin
            div_left <= wait_k;
            div_busy <= (wait_k != 0);
        end else if (div_left > 1) begin
            div_left <= div_left - 1;
        end else begin
            div_left <= 0;
            div_busy <= 1'b0;
        end
    end

    //////////////////////////////
    // expected responses
    logic         exp_gr_in;
    unit_start_t  exp_start;
    hilo_src_t    exp_hilo_src;
    gr_waddr_t    exp_waddr;

    always_comb begin
        exp_gr_in = (is_load(instr_type) && (pos == 5))
                  || ((alu_dest(instr_type) != 0) && (pos == 4));
        exp_start = '0;
        if (is_muldiv(instr_type) && (pos == 3)) begin
            if (instr_type inside {it_mult, it_multu}) begin
                exp_start.mult_start  = 1'b1;
                exp_start.mult_signed = (instr_type == it_mult);
            end else begin
                exp_start.div_start  = 1'b1;
                exp_start.div_signed = (instr_type == it_div);
            end
        end
        exp_hilo_src = (instr_type inside {it_mult, it_multu}) ? hilo_mult : hilo_div;
        exp_waddr    = (alu_dest(instr_type) == 1) ? gr_wa_rd : gr_wa_rt;
    end

    reset_idle: assert property (@(posedge clk) (cycles > 0 && pos == 0)
        |-> (strobes == '0 && start == '0 && !instr_done))
        else report_mismatch("reset_idle", 0, $sampled({strobes, start, instr_done}));
    fetch: assert property (@(posedge clk) cycles > 0 |-> strobes.im_r == (pos == 1))
        else report_mismatch("fetch", $sampled(pos == 1), $sampled(strobes.im_r));
    length: assert property (@(posedge clk) pos > 0 |-> instr_done == (pos == len))
        else report_mismatch("length", $sampled(pos == len), $sampled(instr_done));
    branch_pc: assert property (@(posedge clk) (pos > 2 && is_branch(instr_type))
        |-> (strobes.pc_in && selects.pc_src == pc_src_z) == (pos == 6 && taken))
        else report_mismatch("branch_pc", $sampled(pos == 6 && taken),
            $sampled(strobes.pc_in && selects.pc_src == pc_src_z));
    load_read: assert property (@(posedge clk) (pos > 0 && is_load(instr_type))
        |-> strobes.m_r == (pos == 4))
        else report_mismatch("load_read", $sampled(pos == 4), $sampled(strobes.m_r));
    load_wb: assert property (@(posedge clk) (pos == 5 && is_load(instr_type))
        |-> (selects.gr_wdata == gr_wd_drr && selects.gr_waddr == gr_wa_rt))
        else report_mismatch("load_wb", {gr_wd_drr, gr_wa_rt},
            $sampled({selects.gr_wdata, selects.gr_waddr}));
    store_write: assert property (@(posedge clk) (pos > 0 && is_store(instr_type))
        |-> strobes.m_w == (pos == 5))
        else report_mismatch("store_write", $sampled(pos == 5), $sampled(strobes.m_w));
    gr_write: assert property (@(posedge clk)
        (pos > 0 && (is_load(instr_type) || alu_dest(instr_type) != 0))
        |-> strobes.gr_in == exp_gr_in)
        else report_mismatch("gr_write", $sampled(exp_gr_in), $sampled(strobes.gr_in));
    dmem_flags: assert property (@(posedge clk) pos > 0 |-> dmem == expected_dmem(instr_type))
        else report_mismatch("dmem_flags", $sampled(expected_dmem(instr_type)), $sampled(dmem));
    unit_start: assert property (@(posedge clk) pos > 0 |-> start == exp_start)
        else report_mismatch("unit_start", $sampled(exp_start), $sampled(start));
    hilo_write: assert property (@(posedge clk) (pos > 0 && is_muldiv(instr_type))
        |-> (strobes.hi_in == (pos == len) && strobes.lo_in == (pos == len)))
        else report_mismatch("hilo_write", $sampled(pos == len) * 3,
            $sampled({strobes.hi_in, strobes.lo_in}));
    hilo_src: assert property (@(posedge clk) (pos == len && is_muldiv(instr_type))
        |-> (selects.hi_src == exp_hilo_src && selects.lo_src == exp_hilo_src))
        else report_mismatch("hilo_src", $sampled({exp_hilo_src, exp_hilo_src}),
            $sampled({selects.hi_src, selects.lo_src}));
    alu_code: assert property (@(posedge clk) (pos == 3 && alu_dest(instr_type) != 0)
        |-> selects.alu_code == alu_op_in)
        else report_mismatch("alu_code", $sampled(alu_op_in), $sampled(selects.alu_code));
    alu_waddr: assert property (@(posedge clk) (pos == 4 && alu_dest(instr_type) != 0)
        |-> selects.gr_waddr == exp_waddr)
        else report_mismatch("alu_waddr", $sampled(exp_waddr), $sampled(selects.gr_waddr));

    //////////////////////////////
    // stimulus and end of run
    initial begin
        void'($urandom(32'h1b8b));
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // idle T8 cycle, then the first fetch
        @(posedge clk);
        launch_instr();
        forever begin
            @(posedge clk);
            if (cycles >= cycle_limit) begin
                timed_out = 1'b1;
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                break;
            end
            if (instr_done) begin
                if (issued == n_instr) begin
                    break;
                end
                launch_instr();
            end else begin
                pos <= pos + 1;
            end
        end
        // assertion actions of the last edge run before the summary
        @(negedge clk);
        $display("errors: %0d, timeouts: %0d, instructions: %0d", errors, timed_out, issued);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
